// File: slide_trace.txt
// op(0 up, 1 down) sew(0 e8, 1 e16, 2 e32) offset vl vs2 vd source expected_mask expected_data
// data columns are 128-bit hex, byte 15 first; data is compared at enabled bytes only
0 0 00000001 10 01 02 0f0e0d0c0b0a09080706050403020100 fffe 0e0d0c0b0a0908070605040302010000
0 0 00000003 10 03 04 0f0e0d0c0b0a09080706050403020100 fff8 0c0b0a09080706050403020100000000
0 0 00000005 10 05 06 0f0e0d0c0b0a09080706050403020100 ffe0 0a090807060504030201000000000000
0 1 00000001 08 07 08 0f0e0d0c0b0a09080706050403020100 fffc 0d0c0b0a090807060504030201000000
0 1 00000003 08 09 0a 0f0e0d0c0b0a09080706050403020100 ffc0 09080706050403020100000000000000
0 2 00000001 04 0b 0c afaeadacabaaa9a8a7a6a5a4a3a2a1a0 fff0 abaaa9a8a7a6a5a4a3a2a1a000000000
0 2 00000002 04 0d 0e 0f0e0d0c0b0a09080706050403020100 ff00 07060504030201000000000000000000
0 0 00000000 10 0f 10 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 ffff afaeadacabaaa9a8a7a6a5a4a3a2a1a0
1 0 00000001 10 11 12 0f0e0d0c0b0a09080706050403020100 ffff 000f0e0d0c0b0a090807060504030201
1 0 00000006 10 13 14 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 ffff 000000000000afaeadacabaaa9a8a7a6
1 1 00000002 08 15 16 0f0e0d0c0b0a09080706050403020100 ffff 000000000f0e0d0c0b0a090807060504
1 2 00000001 04 17 18 0f0e0d0c0b0a09080706050403020100 ffff 000000000f0e0d0c0b0a090807060504
1 2 00000003 04 19 1a 0f0e0d0c0b0a09080706050403020100 ffff 0000000000000000000000000f0e0d0c
1 1 00000005 08 1b 1c 0f0e0d0c0b0a09080706050403020100 ffff 000000000000000000000f0e0d0c0b0a
0 0 00000002 0a 1d 1e 0f0e0d0c0b0a09080706050403020100 03fc 00000000000007060504030201000000
1 1 00000001 05 1f 00 0f0e0d0c0b0a09080706050403020100 03ff 0000000000000b0a0908070605040302
1 2 00000000 02 02 03 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 00ff 0000000000000000a7a6a5a4a3a2a1a0
0 1 00000000 00 04 05 0f0e0d0c0b0a09080706050403020100 0000 00000000000000000000000000000000
1 0 00000003 00 06 07 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000 00000000000000000000000000000000
0 0 00000010 10 08 09 0f0e0d0c0b0a09080706050403020100 0000 00000000000000000000000000000000
0 2 00000004 04 0a 0b afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0000 00000000000000000000000000000000
0 1 00010008 08 0c 0d 0f0e0d0c0b0a09080706050403020100 0000 00000000000000000000000000000000
1 0 00000014 10 0e 0f afaeadacabaaa9a8a7a6a5a4a3a2a1a0 ffff 00000000000000000000000000000000
1 1 00000008 06 10 11 0f0e0d0c0b0a09080706050403020100 0fff 00000000000000000000000000000000
1 2 80000001 03 12 13 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 0fff 00000000000000000000000000000000
0 0 0000000f 10 14 15 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 8000 a0000000000000000000000000000000
1 0 0000000f 10 16 17 afaeadacabaaa9a8a7a6a5a4a3a2a1a0 ffff 000000000000000000000000000000af
0 1 00000007 08 18 19 0f0e0d0c0b0a09080706050403020100 c000 01000000000000000000000000000000

// File: filelist.f
slide_pkg.sv
slide_sequencer.sv
slide_operand_buffer.sv
slide_result_assembler.sv
slide_unit.sv
tb_slide_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_slide_unit
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_slide_unit.sv
// slide unit testbench
// replays trace operations through the DUT and checks every register-file write

`timescale 1ns/1ps

module tb_slide_unit import slide_pkg::*; ();

    localparam int unsigned CLK_PERIOD    = 4;
    localparam int unsigned RST_CYCLES    = 16;
    localparam int unsigned FIELDS        = 9;
    localparam int unsigned MAX_OPS       = 64;
    localparam int unsigned CYCLES_PER_OP = 20;

    // trace columns
    localparam int unsigned F_OP     = 0;
    localparam int unsigned F_SEW    = 1;
    localparam int unsigned F_OFFSET = 2;
    localparam int unsigned F_VL     = 3;
    localparam int unsigned F_VS2    = 4;
    localparam int unsigned F_VD     = 5;
    localparam int unsigned F_SRC    = 6;
    localparam int unsigned F_MASK   = 7;
    localparam int unsigned F_DATA   = 8;

    logic            clk_i;
    logic            async_rst_ni;
    logic            op_valid_i;
    sld_op_e         op_i;
    sew_e            sew_i;
    logic [31:0]     offset_i;
    logic [VL_W-1:0] vl_i;
    vaddr_t          vs2_i;
    vaddr_t          vd_i;
    logic            busy_o;
    vaddr_t          vreg_rd_addr_o;
    vreg_t           vreg_rd_i;
    logic            vreg_wr_en_o;
    vaddr_t          vreg_wr_addr_o;
    vreg_t           vreg_wr_o;
    vmask_t          vreg_wr_mask_o;

    vreg_t       regfile [32];
    vreg_t       trace_mem [MAX_OPS * FIELDS];
    int unsigned num_ops;
    int unsigned pending_q [$];
    logic        trace_loaded;
    integer      seed;

    slide_unit #(
        .VREG_W  (VREG_W),
        .CHUNK_W (CHUNK_W)
    ) dut_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .offset_i       (offset_i),
        .vl_i           (vl_i),
        .vs2_i          (vs2_i),
        .vd_i           (vd_i),
        .busy_o         (busy_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // register file with a one-cycle synchronous read
    always @(posedge clk_i) begin
        vreg_rd_i <= regfile[vreg_rd_addr_o];
    end

    //////////////////////////////////////////////////////////////////////
    // helpers

    function automatic int unsigned trace_index(input int unsigned n, input int unsigned f);
        return n * FIELDS + f;
    endfunction

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_addr(input vaddr_t got, input vaddr_t exp, input int unsigned n);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR at %0t ns: op %0d write address %0d, expected %0d",
                                        $time, n, got, exp));
        end
    endtask

    task automatic check_mask(input vmask_t got, input vmask_t exp, input int unsigned n);
        if (got !== exp) begin
            stop_with_failure($sformatf("ERROR at %0t ns: op %0d write mask %h, expected %h",
                                        $time, n, got, exp));
        end
    endtask

    // only enabled bytes carry defined data
    task automatic check_data(input vreg_t got, input vreg_t exp, input vmask_t enable,
                              input int unsigned n);
        for (int b = 0; b < VBYTES; b++) begin
            if (enable[b] && got[b*8 +: 8] !== exp[b*8 +: 8]) begin
                stop_with_failure($sformatf(
                    "ERROR at %0t ns: op %0d data byte %0d is %h, expected %h",
                    $time, n, b, got[b*8 +: 8], exp[b*8 +: 8]));
            end
        end
    endtask

    task automatic load_trace();
        for (int i = 0; i < MAX_OPS * FIELDS; i++) begin
            trace_mem[i] = ~vreg_t'(i);
        end
        $readmemh("slide_trace.txt", trace_mem);
        num_ops = 0;
        // an op column that still holds its inverted-address fill marks the end
        while (num_ops < MAX_OPS &&
               trace_mem[trace_index(num_ops, F_OP)] !==
               ~vreg_t'(trace_index(num_ops, F_OP))) begin
            num_ops++;
        end
        if (num_ops == 0) begin
            stop_with_failure("no operations could be read from slide_trace.txt");
        end
        trace_loaded = 1'b1;
    endtask

    task automatic issue_op(input int unsigned n);
        regfile[trace_mem[trace_index(n, F_VS2)][4:0]] <= trace_mem[trace_index(n, F_SRC)];
        op_valid_i <= 1'b1;
        op_i       <= sld_op_e'(trace_mem[trace_index(n, F_OP)][0]);
        sew_i      <= sew_e'(trace_mem[trace_index(n, F_SEW)][1:0]);
        offset_i   <= trace_mem[trace_index(n, F_OFFSET)][31:0];
        vl_i       <= trace_mem[trace_index(n, F_VL)][VL_W-1:0];
        vs2_i      <= trace_mem[trace_index(n, F_VS2)][4:0];
        vd_i       <= trace_mem[trace_index(n, F_VD)][4:0];
        pending_q.push_back(n);
        @(posedge clk_i);
        op_valid_i <= 1'b0;
        // busy stays high for CHUNKS+1 cycles after acceptance
        repeat (CHUNKS + 1) @(posedge clk_i);
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus, write checker and watchdog

    initial begin : stimulus
        int unsigned gap;
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        op_valid_i   = 1'b0;
        op_i         = SLD_UP;
        sew_i        = SEW_8;
        offset_i     = '0;
        vl_i         = '0;
        vs2_i        = '0;
        vd_i         = '0;
        vreg_rd_i    = '0;
        trace_loaded = 1'b0;
        seed         = 32'hef21;
        for (int r = 0; r < 32; r++) begin
            regfile[r] = {VBYTES{8'(r)}};
        end
        load_trace();
        repeat (RST_CYCLES) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        for (int unsigned n = 0; n < num_ops; n++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(posedge clk_i);
            issue_op(n);
        end
        while (pending_q.size() != 0) begin
            @(posedge clk_i);
        end
        // leave room for a stray extra write to show up
        repeat (CHUNKS + 6) @(posedge clk_i);
        $display("Regression passed");
        $finish;
    end

    always @(negedge clk_i) begin : write_monitor
        int unsigned n;
        if (async_rst_ni && op_valid_i && busy_o) begin
            stop_with_failure("the DUT was still busy in a cycle where a new operation was due");
        end
        if (async_rst_ni && vreg_wr_en_o) begin
            if (pending_q.size() == 0) begin
                stop_with_failure("the DUT wrote a register with no operation outstanding");
            end else begin
                n = pending_q.pop_front();
                check_addr(vreg_wr_addr_o, trace_mem[trace_index(n, F_VD)][4:0], n);
                check_mask(vreg_wr_mask_o, trace_mem[trace_index(n, F_MASK)][VBYTES-1:0], n);
                check_data(vreg_wr_o, trace_mem[trace_index(n, F_DATA)],
                           trace_mem[trace_index(n, F_MASK)][VBYTES-1:0], n);
            end
        end
    end

    initial begin : watchdog
        wait (trace_loaded);
        #(CLK_PERIOD * (RST_CYCLES + CYCLES_PER_OP * num_ops));
        stop_with_failure("timeout: the DUT did not complete the trace in time");
    end

endmodule

// File: slide_unit.sv
// vector slide unit top level
// sequencer, operand buffer and result assembler for slide-up and slide-down

`timescale 1ns/1ps

module slide_unit import slide_pkg::*; #(
    parameter int unsigned VREG_W  = slide_pkg::VREG_W,
    parameter int unsigned CHUNK_W = slide_pkg::CHUNK_W
) (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      op_valid_i,
    input  sld_op_e                   op_i,
    input  sew_e                      sew_i,
    input  logic [31:0]               offset_i,
    input  logic [$clog2(VREG_W/8):0] vl_i,
    input  vaddr_t                    vs2_i,
    input  vaddr_t                    vd_i,
    output logic                      busy_o,
    output vaddr_t                    vreg_rd_addr_o,
    input  logic [VREG_W-1:0]         vreg_rd_i,
    output logic                      vreg_wr_en_o,
    output vaddr_t                    vreg_wr_addr_o,
    output logic [VREG_W-1:0]         vreg_wr_o,
    output logic [VREG_W/8-1:0]       vreg_wr_mask_o
);

    localparam int unsigned CSW = $clog2(CHUNK_W / 8);
    localparam int unsigned CIW = $clog2(VREG_W / CHUNK_W);
    localparam int unsigned VLW = $clog2(VREG_W / 8) + 1;

    // sequencer outputs
    logic           fetch;
    logic           seq_step, seq_first, seq_last;
    logic [CSW-1:0] byte_shift;
    logic [CIW-1:0] dst_chunk;
    logic           chunk_valid;
    sld_op_e        pair_op;
    sew_e           pair_sew;
    logic [VLW-1:0] pair_vl;
    vaddr_t         pair_vd;

    // buffer outputs
    logic [CHUNK_W-1:0] operand_low, operand_high;
    logic               low_valid, high_valid;
    logic               pair_step;

    slide_sequencer #(
        .VREG_W  (VREG_W),
        .CHUNK_W (CHUNK_W)
    ) sequencer_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_valid_i     (op_valid_i),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .offset_i       (offset_i),
        .vl_i           (vl_i),
        .vs2_i          (vs2_i),
        .vd_i           (vd_i),
        .busy_o         (busy_o),
        .fetch_o        (fetch),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .step_o         (seq_step),
        .first_o        (seq_first),
        .last_o         (seq_last),
        .byte_shift_o   (byte_shift),
        .dst_chunk_o    (dst_chunk),
        .chunk_valid_o  (chunk_valid),
        .op_o           (pair_op),
        .sew_o          (pair_sew),
        .vl_o           (pair_vl),
        .vd_o           (pair_vd)
    );

    slide_operand_buffer #(
        .VREG_W  (VREG_W),
        .CHUNK_W (CHUNK_W)
    ) buffer_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .fetch_i        (fetch),
        .step_i         (seq_step),
        .first_i        (seq_first),
        .last_i         (seq_last),
        .op_i           (pair_op),
        .vreg_rd_i      (vreg_rd_i),
        .operand_low_o  (operand_low),
        .operand_high_o (operand_high),
        .low_valid_o    (low_valid),
        .high_valid_o   (high_valid),
        .step_o         (pair_step)
    );

    slide_result_assembler #(
        .VREG_W  (VREG_W),
        .CHUNK_W (CHUNK_W)
    ) assembler_i (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .step_i         (pair_step),
        .operand_low_i  (operand_low),
        .operand_high_i (operand_high),
        .low_valid_i    (low_valid),
        .high_valid_i   (high_valid),
        .byte_shift_i   (byte_shift),
        .dst_chunk_i    (dst_chunk),
        .chunk_valid_i  (chunk_valid),
        .op_i           (pair_op),
        .sew_i          (pair_sew),
        .vl_i           (pair_vl),
        .vd_i           (pair_vd),
        .vreg_wr_en_o   (vreg_wr_en_o),
        .vreg_wr_addr_o (vreg_wr_addr_o),
        .vreg_wr_o      (vreg_wr_o),
        .vreg_wr_mask_o (vreg_wr_mask_o)
    );

endmodule

// File: slide_result_assembler.sv
// slide result assembler
// byte-shifts each operand pair into a chunk, collects the result register
// and byte mask, and issues one register-file write per operation

`timescale 1ns/1ps

module slide_result_assembler import slide_pkg::*; #(
    parameter int unsigned VREG_W  = slide_pkg::VREG_W,
    parameter int unsigned CHUNK_W = slide_pkg::CHUNK_W
) (
    input  logic                              clk_i,
    input  logic                              async_rst_ni,
    input  logic                              step_i,
    input  logic [CHUNK_W-1:0]                operand_low_i,
    input  logic [CHUNK_W-1:0]                operand_high_i,
    input  logic                              low_valid_i,
    input  logic                              high_valid_i,
    input  logic [$clog2(CHUNK_W/8)-1:0]      byte_shift_i,
    input  logic [$clog2(VREG_W/CHUNK_W)-1:0] dst_chunk_i,
    input  logic                              chunk_valid_i,
    input  sld_op_e                           op_i,
    input  sew_e                              sew_i,
    input  logic [$clog2(VREG_W/8):0]         vl_i,
    input  vaddr_t                            vd_i,
    output logic                              vreg_wr_en_o,
    output vaddr_t                            vreg_wr_addr_o,
    output logic [VREG_W-1:0]                 vreg_wr_o,
    output logic [VREG_W/8-1:0]               vreg_wr_mask_o
);

    localparam int unsigned CB  = CHUNK_W / 8;
    localparam int unsigned NB  = VREG_W / 8;
    localparam int unsigned CIW = $clog2(VREG_W / CHUNK_W);
    localparam int unsigned VLW = $clog2(NB) + 1;

    //////////////////////////////////////////////////////////////////////
    // byte selection and masking

    logic [VLW+1:0]     vl_bytes;
    logic [NB-1:0]      vl_mask;
    logic [CHUNK_W-1:0] sel_data;
    logic [CB-1:0]      sel_valid;
    logic [CB-1:0]      sel_mask;
    logic [NB-1:0]      init_mask;

    assign vl_bytes = {2'b00, vl_i} << sew_i;

    always_comb begin
        for (int unsigned j = 0; j < NB; j++) begin
            vl_mask[j] = j < 32'(vl_bytes);
        end
    end

    always_comb begin
        int idx;
        for (int i = 0; i < CB; i++) begin
            idx = i + int'(byte_shift_i);
            if (idx < CB) begin
                sel_data[i*8 +: 8] = operand_low_i[idx*8 +: 8];
                sel_valid[i]       = low_valid_i;
            end else begin
                sel_data[i*8 +: 8] = operand_high_i[(idx-CB)*8 +: 8];
                // zeros past the register end are real data for slide-down
                sel_valid[i]       = high_valid_i | (op_i == SLD_DOWN);
            end
        end
    end

    assign sel_mask  = sel_valid & vl_mask[dst_chunk_i*CB +: CB];
    // slide-down chunks that are never produced are zero and enabled below vl
    assign init_mask = (op_i == SLD_DOWN) ? vl_mask : '0;

    //////////////////////////////////////////////////////////////////////
    // chunk stage

    logic               r_step_q;
    logic               r_first_q;
    logic               r_last_q;
    logic               r_valid_q;
    logic [CIW-1:0]     r_dst_q;
    logic [CHUNK_W-1:0] r_data_q;
    logic [CB-1:0]      r_mask_q;
    logic [NB-1:0]      r_init_q;
    vaddr_t             r_vd_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            r_step_q <= 1'b0;
        end else begin
            r_step_q <= step_i;
        end
    end

    always_ff @(posedge clk_i) begin
        r_first_q <= ~low_valid_i;
        r_last_q  <= ~high_valid_i;
        r_valid_q <= chunk_valid_i;
        r_dst_q   <= dst_chunk_i;
        r_data_q  <= sel_data;
        r_mask_q  <= sel_mask;
        r_init_q  <= init_mask;
        r_vd_q    <= vd_i;
    end

    //////////////////////////////////////////////////////////////////////
    // result register and write

    logic [VREG_W-1:0] result_q, result_next;
    logic [NB-1:0]     wmask_q, wmask_next;
    logic              wr_en_q;
    vaddr_t            wr_addr_q;

    always_comb begin
        result_next = r_first_q ? '0 : result_q;
        wmask_next  = r_first_q ? r_init_q : wmask_q;
        if (r_valid_q) begin
            result_next[r_dst_q*CHUNK_W +: CHUNK_W] = r_data_q;
            wmask_next[r_dst_q*CB +: CB]            = r_mask_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (r_step_q) begin
            result_q <= result_next;
            wmask_q  <= wmask_next;
        end
        if (r_step_q && r_last_q) begin
            wr_addr_q <= r_vd_q;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= r_step_q & r_last_q;
        end
    end

    assign vreg_wr_en_o   = wr_en_q;
    assign vreg_wr_addr_o = wr_addr_q;
    assign vreg_wr_o      = result_q;
    assign vreg_wr_mask_o = wmask_q;

endmodule

// File: slide_operand_buffer.sv
// slide operand buffer
// holds the source register and releases adjacent low/high chunk pairs

`timescale 1ns/1ps

module slide_operand_buffer import slide_pkg::*; #(
    parameter int unsigned VREG_W  = slide_pkg::VREG_W,
    parameter int unsigned CHUNK_W = slide_pkg::CHUNK_W
) (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               fetch_i,
    input  logic               step_i,
    input  logic               first_i,
    input  logic               last_i,
    // aligned with the operand outputs
    input  sld_op_e            op_i,
    input  logic [VREG_W-1:0]  vreg_rd_i,
    output logic [CHUNK_W-1:0] operand_low_o,
    output logic [CHUNK_W-1:0] operand_high_o,
    output logic               low_valid_o,
    output logic               high_valid_o,
    output logic               step_o
);

    logic fetch_q;
    logic s1_step_q, s1_first_q, s1_last_q;
    logic s2_step_q, s2_first_q, s2_last_q;

    logic [VREG_W-1:0]  vs2_shift_q;
    logic [CHUNK_W-1:0] low_q;
    logic [CHUNK_W-1:0] high_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            fetch_q    <= 1'b0;
            s1_step_q  <= 1'b0;
            s1_first_q <= 1'b0;
            s1_last_q  <= 1'b0;
            s2_step_q  <= 1'b0;
            s2_first_q <= 1'b0;
            s2_last_q  <= 1'b0;
        end else begin
            fetch_q    <= fetch_i;
            s1_step_q  <= step_i;
            s1_first_q <= first_i;
            s1_last_q  <= last_i;
            s2_step_q  <= s1_step_q;
            s2_first_q <= s1_first_q;
            s2_last_q  <= s1_last_q;
        end
    end

    // the register arrives one cycle after fetch, then drains one chunk per step
    always_ff @(posedge clk_i) begin
        if (fetch_q) begin
            vs2_shift_q <= vreg_rd_i;
        end else if (s1_step_q) begin
            vs2_shift_q <= vs2_shift_q >> CHUNK_W;
        end
    end

    // the previous high chunk becomes the low chunk of the next pair
    always_ff @(posedge clk_i) begin
        if (s1_step_q) begin
            low_q  <= high_q;
            high_q <= vs2_shift_q[CHUNK_W-1:0];
        end
    end

    assign operand_low_o  = low_q;
    // chunk past the register end reads as zero for slide-down
    assign operand_high_o = (s2_last_q && op_i == SLD_DOWN) ? '0 : high_q;
    assign low_valid_o    = ~s2_first_q;
    assign high_valid_o   = ~s2_last_q;
    assign step_o         = s2_step_q;

endmodule

// File: slide_sequencer.sv
// slide sequencer
// accepts one operation, turns the element offset into a byte slide and
// steps through the chunks of the source register

`timescale 1ns/1ps

module slide_sequencer import slide_pkg::*; #(
    parameter int unsigned VREG_W  = slide_pkg::VREG_W,
    parameter int unsigned CHUNK_W = slide_pkg::CHUNK_W
) (
    input  logic                                 clk_i,
    input  logic                                 async_rst_ni,
    input  logic                                 op_valid_i,
    input  sld_op_e                              op_i,
    input  sew_e                                 sew_i,
    input  logic [31:0]                          offset_i,
    input  logic [$clog2(VREG_W/8):0]            vl_i,
    input  vaddr_t                               vs2_i,
    input  vaddr_t                               vd_i,
    output logic                                 busy_o,
    output logic                                 fetch_o,
    output vaddr_t                               vreg_rd_addr_o,
    output logic                                 step_o,
    output logic                                 first_o,
    output logic                                 last_o,
    output logic [$clog2(CHUNK_W/8)-1:0]         byte_shift_o,
    output logic [$clog2(VREG_W/CHUNK_W)-1:0]    dst_chunk_o,
    output logic                                 chunk_valid_o,
    output sld_op_e                              op_o,
    output sew_e                                 sew_o,
    output logic [$clog2(VREG_W/8):0]            vl_o,
    output vaddr_t                               vd_o
);

    localparam int unsigned NCH  = VREG_W / CHUNK_W;
    localparam int unsigned SLW  = $clog2(VREG_W / 8);
    localparam int unsigned CSW  = $clog2(CHUNK_W / 8);
    localparam int unsigned CIW  = $clog2(NCH);
    localparam int unsigned VLW  = SLW + 1;
    // destination chunk index with two extra bits, negative or beyond means no store
    localparam int unsigned DW   = CIW + 2;
    localparam int unsigned CNTW = $clog2(NCH + 1);

    logic accept;
    assign accept = op_valid_i & ~busy_o;

    //////////////////////////////////////////////////////////////////////
    // byte slide and start position

    logic [SLW-1:0] byte_slide;
    logic           in_range;
    logic [DW-1:0]  dst_start;
    logic [CSW-1:0] shift_start;

    always_comb begin
        byte_slide = '0;
        in_range   = 1'b0;
        case (sew_i)
            SEW_8: begin
                byte_slide = offset_i[SLW-1:0];
                in_range   = (offset_i >> SLW) == 32'd0;
            end
            SEW_16: begin
                byte_slide = {offset_i[SLW-2:0], 1'b0};
                in_range   = (offset_i >> (SLW - 1)) == 32'd0;
            end
            SEW_32: begin
                byte_slide = {offset_i[SLW-3:0], 2'b00};
                in_range   = (offset_i >> (SLW - 2)) == 32'd0;
            end
            default: ;
        endcase
    end

    always_comb begin
        if (op_i == SLD_UP) begin
            // a whole-chunk slide takes its data from the low operand one step later
            dst_start   = DW'(byte_slide[SLW-1:CSW]) - DW'(byte_slide[CSW-1:0] == '0);
            shift_start = CSW'(0) - byte_slide[CSW-1:0];
        end else begin
            dst_start   = ~DW'(byte_slide[SLW-1:CSW]);
            shift_start = byte_slide[CSW-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // operation state and step counter

    logic            busy_q;
    logic [CNTW-1:0] cnt_q;
    logic [DW-1:0]   dst_q;
    logic            last;

    sld_op_e         op_q;
    sew_e            sew_q;
    logic [VLW-1:0]  vl_q;
    vaddr_t          vd_q;
    logic [CSW-1:0]  shift_q;
    logic            in_range_q;

    assign last = busy_q & (cnt_q == CNTW'(NCH));

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            dst_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
            dst_q  <= dst_start;
        end else if (busy_q) begin
            cnt_q  <= cnt_q + 1'b1;
            dst_q  <= dst_q + 1'b1;
            if (last) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q       <= op_i;
            sew_q      <= sew_i;
            vl_q       <= vl_i;
            vd_q       <= vd_i;
            shift_q    <= shift_start;
            in_range_q <= in_range;
        end
    end

    assign busy_o         = busy_q;
    assign fetch_o        = accept;
    // source register is read once, in the accept cycle
    assign vreg_rd_addr_o = vs2_i;
    assign step_o         = busy_q;
    assign first_o        = busy_q & (cnt_q == '0);
    assign last_o         = last;

    //////////////////////////////////////////////////////////////////////
    // delay the per-step fields by the two buffer stages

    logic [CSW-1:0] shift_p [2];
    logic [CIW-1:0] dst_p   [2];
    logic           valid_p [2];
    sld_op_e        op_p    [2];
    sew_e           sew_p   [2];
    logic [VLW-1:0] vl_p    [2];
    vaddr_t         vd_p    [2];

    always_ff @(posedge clk_i) begin
        shift_p[0] <= shift_q;
        dst_p[0]   <= dst_q[CIW-1:0];
        valid_p[0] <= in_range_q & (dst_q[DW-1:CIW] == 2'b00);
        op_p[0]    <= op_q;
        sew_p[0]   <= sew_q;
        vl_p[0]    <= vl_q;
        vd_p[0]    <= vd_q;
        shift_p[1] <= shift_p[0];
        dst_p[1]   <= dst_p[0];
        valid_p[1] <= valid_p[0];
        op_p[1]    <= op_p[0];
        sew_p[1]   <= sew_p[0];
        vl_p[1]    <= vl_p[0];
        vd_p[1]    <= vd_p[0];
    end

    assign byte_shift_o  = shift_p[1];
    assign dst_chunk_o   = dst_p[1];
    assign chunk_valid_o = valid_p[1];
    assign op_o          = op_p[1];
    assign sew_o         = sew_p[1];
    assign vl_o          = vl_p[1];
    assign vd_o          = vd_p[1];

endmodule

// File: slide_pkg.sv
// slide unit shared definitions
// register and chunk geometry, element width and operation encodings

package slide_pkg;

    // register geometry
    parameter int unsigned VREG_W   = 128;
    parameter int unsigned CHUNK_W  = 32;
    parameter int unsigned CHUNKS   = VREG_W / CHUNK_W;
    parameter int unsigned VBYTES   = VREG_W / 8;
    parameter int unsigned BSHIFT_W = $clog2(VBYTES);
    // vl counts elements, up to VBYTES for byte elements
    parameter int unsigned VL_W     = BSHIFT_W + 1;

    typedef logic [VREG_W-1:0]  vreg_t;
    typedef logic [VBYTES-1:0]  vmask_t;
    typedef logic [CHUNK_W-1:0] chunk_t;
    typedef logic [4:0]         vaddr_t;

    // encoding is log2 of the element size in bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef enum logic {
        SLD_UP   = 1'b0,
        SLD_DOWN = 1'b1
    } sld_op_e;

endpackage
